// File: design/histPkg.sv
package histPkg;

    // APB register bus
    localparam int APB_ADDR_BITS = 12;
    localparam int APB_DATA_BITS = 32;

    // controller states, also reported in STATUS[6:4]
    typedef enum logic [2:0] {
        IDLE    = 3'd0,     // waiting for start
        CLEAR   = 3'd1,     // zeroing all bins
        ACQUIRE = 3'd2,     // counting events
        DRAIN   = 3'd3,     // last write-back in flight
        DONE    = 3'd4      // histogram ready for readout
    } histState_t;

    // register map
    typedef enum logic [APB_ADDR_BITS-1:0] {
        CTRL    = 12'h000,  // start bit and event target
        STATUS  = 12'h004,  // busy, done, state
        EVENTS  = 12'h008,  // accepted event count
        BINBASE = 12'h100   // first bin word
    } regAddr_t;

endpackage

// File: design/histRam.sv
module histRam #(
    parameter int binBits = 6,
    parameter int countBits = 16
) (
    input  logic                 clk,
    input  logic                 wrEn,
    input  logic [binBits-1:0]   wrAddr,
    input  logic [countBits-1:0] wrData,
    input  logic [binBits-1:0]   rdAddrA,
    input  logic [binBits-1:0]   rdAddrB,
    output logic [countBits-1:0] rdDataA,
    output logic [countBits-1:0] rdDataB
);

    localparam int depth = 2 ** binBits;

    logic [countBits-1:0] mem [depth];  // one count per bin

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // both ports see the old word on a same-edge collision
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA];        // controller side
        rdDataB <= mem[rdAddrB];        // APB readout side
    end

    // a write with an unknown address would corrupt a random bin
    assert property (@(posedge clk) wrEn |-> !$isunknown(wrAddr))
        else $error("histRam write with unknown address");

endmodule

// File: design/histController.sv
module histController #(
    parameter int binBits = 6,
    parameter int countBits = 16,
    parameter int eventBits = 24
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 eventValid,
    input  logic [binBits-1:0]   eventBin,
    input  logic                 start,
    input  logic [eventBits-1:0] eventTarget,
    input  logic [countBits-1:0] rdData,
    output logic                 eventReady,
    output logic                 busy,
    output logic                 done,
    output histPkg::histState_t  state,
    output logic [eventBits-1:0] eventCount,
    output logic                 wrEn,
    output logic [binBits-1:0]   wrAddr,
    output logic [countBits-1:0] wrData,
    output logic [binBits-1:0]   rdAddr
);
    import histPkg::*;

    logic                 accept;
    logic                 s1Valid;      // event waiting for its read data
    logic [binBits-1:0]   s1Bin;
    logic                 lastValid;    // word written on the previous edge
    logic [binBits-1:0]   lastBin;
    logic [countBits-1:0] lastData;
    logic [countBits-1:0] oldCount;
    logic [countBits-1:0] newCount;

    assign eventReady = (state == ACQUIRE) && (eventCount != eventTarget);
    assign accept = eventValid && eventReady;
    assign rdAddr = eventBin;           // read issued on the accept edge
    assign busy = (state == CLEAR) || (state == ACQUIRE) || (state == DRAIN);
    assign done = (state == DONE);

    // Memory data can be stale by up to two events. The write stage holds the
    // newest count, and the word written on the last edge collided with our read.
    always_comb begin
        if (wrEn && wrAddr == s1Bin) begin
            oldCount = wrData;
        end else if (lastValid && lastBin == s1Bin) begin
            oldCount = lastData;
        end else begin
            oldCount = rdData;
        end
        newCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;  // saturate
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            eventCount <= '0;
            s1Valid <= 1'b0;
            lastValid <= 1'b0;
            wrEn <= 1'b0;
        end else begin
            s1Valid <= accept;
            lastValid <= wrEn;
            case (state)
                IDLE, DONE: begin
                    wrEn <= 1'b0;
                    if (start) begin
                        state <= CLEAR;
                        eventCount <= '0;
                        wrEn <= 1'b1;           // first clear write
                    end
                end
                CLEAR: begin
                    if (&wrAddr) begin
                        state <= ACQUIRE;
                        wrEn <= 1'b0;
                    end
                end
                ACQUIRE: begin
                    wrEn <= s1Valid;
                    if (accept) begin
                        eventCount <= eventCount + 1'b1;
                    end
                    if (eventCount == eventTarget) begin
                        state <= DRAIN;         // ready already low
                    end
                end
                DRAIN: begin
                    wrEn <= 1'b0;               // final event is in the write stage
                    state <= DONE;
                end
                default: begin
                    wrEn <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= eventBin;
        lastBin <= wrAddr;
        lastData <= wrData;
        case (state)
            IDLE, DONE: begin
                wrAddr <= '0;
                wrData <= '0;
            end
            CLEAR: begin
                wrAddr <= wrAddr + 1'b1;        // walk all bins
                wrData <= '0;
            end
            default: begin
                wrAddr <= s1Bin;
                wrData <= newCount;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!res)
        !(wrEn && (state == IDLE || state == DONE)))
        else $error("memory write outside clear or acquisition");

    // every accepted event reaches the write port two edges later
    assert property (@(posedge clk) disable iff (!res)
        (state == ACQUIRE || state == DRAIN) |-> wrEn == $past(accept, 2))
        else $error("accepted event not written back on time");

endmodule

// File: design/histApbRegs.sv
module histApbRegs #(
    parameter int binBits = 6,
    parameter int countBits = 16,
    parameter int eventBits = 24
) (
    input  logic                              clk,
    input  logic                              res,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [histPkg::APB_ADDR_BITS-1:0] paddr,
    input  logic [histPkg::APB_DATA_BITS-1:0] pwdata,
    input  logic                              busy,
    input  logic                              done,
    input  histPkg::histState_t               state,
    input  logic [eventBits-1:0]              eventCount,
    input  logic [countBits-1:0]              binData,
    output logic [histPkg::APB_DATA_BITS-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              start,
    output logic [eventBits-1:0]              eventTarget,
    output logic [binBits-1:0]                binAddr
);
    import histPkg::*;

    logic                     access;
    logic                     isReg;
    logic                     isBin;
    logic                     binWait;      // bin read has had its wait cycle
    logic [APB_ADDR_BITS-1:0] binOffset;

    assign access = psel && penable;
    assign binOffset = paddr - BINBASE;
    assign binAddr = binOffset[binBits+1:2];    // word index into the bins
    assign isReg = (paddr == CTRL) || (paddr == STATUS) || (paddr == EVENTS);
    assign isBin = (paddr >= BINBASE) && (binOffset[APB_ADDR_BITS-1:2] < 2 ** binBits);
    assign pready = access && (!isBin || binWait);
    assign pslverr = pready && !isReg && !isBin;    // unmapped offset

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binWait <= 1'b0;
        end else begin
            binWait <= access && isBin && !binWait;
        end
    end

    always_comb begin
        prdata = '0;
        if (isBin) begin
            prdata[countBits-1:0] = binData;
        end else begin
            case (paddr)
                CTRL: begin
                    prdata[8 +: eventBits] = eventTarget;
                end
                STATUS: begin
                    prdata[0] = busy;
                    prdata[1] = done;
                    prdata[6:4] = state;
                end
                EVENTS: begin
                    prdata[eventBits-1:0] = eventCount;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            start <= 1'b0;
            eventTarget <= '0;
        end else begin
            start <= 1'b0;                      // single cycle pulse
            if (pready && pwrite && paddr == CTRL && !busy) begin
                start <= pwdata[0];
                eventTarget <= pwdata[8 +: eventBits];
            end
        end
    end

    // a bin read completes after exactly one wait state
    assert property (@(posedge clk) disable iff (!res)
        access && isBin && !pready |=> pready)
        else $error("bin read did not complete after one wait state");

endmodule

// File: design/histTop.sv
module histTop #(
    parameter int binBits = 6,
    parameter int countBits = 16,
    parameter int eventBits = 24
) (
    input  logic                              clk,
    input  logic                              res,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [histPkg::APB_ADDR_BITS-1:0] paddr,
    input  logic [histPkg::APB_DATA_BITS-1:0] pwdata,
    output logic [histPkg::APB_DATA_BITS-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              eventValid,
    input  logic [binBits-1:0]                eventBin,
    output logic                              eventReady
);
    import histPkg::*;

    logic                 start;
    logic [eventBits-1:0] eventTarget;
    logic                 busy;
    logic                 done;
    histState_t           state;
    logic [eventBits-1:0] eventCount;
    logic                 wrEn;
    logic [binBits-1:0]   wrAddr;
    logic [countBits-1:0] wrData;
    logic [binBits-1:0]   rdAddr;       // controller read-modify-write port
    logic [countBits-1:0] rdData;
    logic [binBits-1:0]   binAddr;      // APB readout port
    logic [countBits-1:0] binData;

    histController #(.binBits(binBits), .countBits(countBits), .eventBits(eventBits)) ctrl (
        .clk(clk), .res(res), .eventValid(eventValid), .eventBin(eventBin),
        .start(start), .eventTarget(eventTarget), .rdData(rdData),
        .eventReady(eventReady), .busy(busy), .done(done), .state(state),
        .eventCount(eventCount), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddr(rdAddr)
    );

    histRam #(.binBits(binBits), .countBits(countBits)) ram (
        .clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddr), .rdAddrB(binAddr), .rdDataA(rdData), .rdDataB(binData)
    );

    histApbRegs #(.binBits(binBits), .countBits(countBits), .eventBits(eventBits)) regs (
        .clk(clk), .res(res), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .done(done), .state(state),
        .eventCount(eventCount), .binData(binData), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .start(start), .eventTarget(eventTarget), .binAddr(binAddr)
    );

endmodule

// File: tests/histTb.sv
module histTb;
    timeunit 1ns;
    timeprecision 1ps;
    import histPkg::*;

    localparam int binBits = 6;
    localparam int countBits = 4;               // small so saturation is reachable
    localparam int eventBits = 24;
    localparam int numBins = 2 ** binBits;
    localparam int waitLimit = 400;

    typedef enum logic [1:0] {FIXED, REPEAT, RANDOM} listMode_t;
    typedef struct packed {
        logic [eventBits-1:0] target;
        listMode_t            mode;
        logic [binBits-1:0]   firstBin;
        logic [7:0]           step;             // stride, run length or random span
    } stimRow_t;

    logic                     clk = 1'b0;
    logic                     res;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     eventValid;
    logic [binBits-1:0]       eventBin;
    logic                     eventReady;

    stimRow_t             stimTable [4];
    logic [countBits-1:0] model [numBins];     // expected bin counts
    int unsigned          lcgState = 19;
    int                   valueErrors = 0;
    int                   otherErrors = 0;

    histTop #(.binBits(binBits), .countBits(countBits), .eventBits(eventBits)) UUT (
        .clk(clk), .res(res), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .eventValid(eventValid), .eventBin(eventBin),
        .eventReady(eventReady)
    );

    always #50 clk = ~clk;

    task automatic checkReg(input string name, input logic [APB_DATA_BITS-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input logic [countBits-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkState(input string name, input histState_t got, exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h (%s)", name, got, exp, exp.name());
            valueErrors++;
        end
    endtask

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;                  // low bits cycle too fast
    endfunction

    function automatic logic [binBits-1:0] binFor(input stimRow_t row, input int i);
        int offset;
        case (row.mode)
            FIXED: offset = i * row.step;
            REPEAT: offset = i / row.step;
            default: offset = lcgNext() % row.step;
        endcase
        return binBits'(row.firstBin + offset);
    endfunction

    task automatic apbTransfer(input logic write, input logic [APB_ADDR_BITS-1:0] addr,
                               input logic [APB_DATA_BITS-1:0] wdata, input logic expectErr,
                               output logic [APB_DATA_BITS-1:0] rdata);
        int cycles;
        psel = 1'b1;                            // setup cycle
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            $display("APB access to offset %h never completed", addr);
            otherErrors++;
        end
        rdata = prdata;
        checkReg($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(expectErr));
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbRead(input logic [APB_ADDR_BITS-1:0] addr,
                           output logic [APB_DATA_BITS-1:0] data);
        apbTransfer(1'b0, addr, '0, 1'b0, data);
    endtask

    task automatic apbWrite(input logic [APB_ADDR_BITS-1:0] addr,
                            input logic [APB_DATA_BITS-1:0] data);
        logic [APB_DATA_BITS-1:0] ignored;
        apbTransfer(1'b1, addr, data, 1'b0, ignored);
    endtask

    task automatic waitForState(input histState_t want);
        logic [APB_DATA_BITS-1:0] status;
        int polls;
        polls = 0;
        apbRead(STATUS, status);
        while (status[6:4] != want && polls < waitLimit) begin
            apbRead(STATUS, status);
            polls++;
        end
        if (status[6:4] != want) begin
            $display("unit never reached state %s", want.name());
            otherErrors++;
        end
    endtask

    task automatic sendEvent(input logic [binBits-1:0] bin);
        int cycles;
        eventValid = 1'b1;                      // held high between events
        eventBin = bin;
        cycles = 0;
        @(negedge clk);
        while (!eventReady && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!eventReady) begin
            $display("event for bin %0d was never accepted", bin);
            otherErrors++;
        end else if (model[bin] != '1) begin
            model[bin] = model[bin] + 1'b1;     // hold at the maximum
        end
        @(posedge clk);
        #1;
    endtask

    task automatic checkBins();
        logic [APB_DATA_BITS-1:0] data;
        for (int b = 0; b < numBins; b++) begin
            apbRead(APB_ADDR_BITS'(BINBASE + 4 * b), data);
            checkCount($sformatf("bin %0d", b), data[countBits-1:0], model[b]);
        end
    endtask

    task automatic runRow(input stimRow_t row, input logic busyProbe);
        logic [APB_DATA_BITS-1:0] data;
        apbWrite(CTRL, {row.target, 8'h01});
        waitForState(ACQUIRE);
        foreach (model[b]) begin
            model[b] = '0;
        end
        checkBins();                            // clear pass must leave zeros
        for (int i = 0; i < row.target; i++) begin
            if (busyProbe && i == row.target / 2) begin
                eventValid = 1'b0;
                apbRead(STATUS, data);
                checkReg("STATUS", data, 32'h21);
                apbWrite(CTRL, {24'd5, 8'h01}); // ignored while busy
                apbRead(EVENTS, data);
                checkReg("EVENTS", data, i);
            end
            sendEvent(binFor(row, i));
        end
        repeat (3) begin
            @(negedge clk);
            checkReg("eventReady", 32'(eventReady), 0);
        end
        @(posedge clk);
        #1 eventValid = 1'b0;
        waitForState(DONE);
        apbRead(STATUS, data);
        checkReg("STATUS", data, 32'h42);
        checkState("state", histState_t'(data[6:4]), DONE);
        apbRead(EVENTS, data);
        checkReg("EVENTS", data, 32'(row.target));
        checkBins();
    endtask

    initial begin
        logic [APB_DATA_BITS-1:0] data;
        res = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        eventValid = 1'b0;
        eventBin = '0;
        stimTable[0] = '{target: 24'd40, mode: FIXED, firstBin: 6'd3, step: 8'd5};
        stimTable[1] = '{target: 24'd30, mode: REPEAT, firstBin: 6'd10, step: 8'd3};
        stimTable[2] = '{target: 24'd100, mode: RANDOM, firstBin: 6'd40, step: 8'd8};
        stimTable[3] = '{target: 24'd20, mode: REPEAT, firstBin: 6'd33, step: 8'd20};
        repeat (5) @(posedge clk);
        #1 res = 1'b1;
        @(negedge clk);
        checkReg("eventReady", 32'(eventReady), 0);
        checkReg("pready", 32'(pready), 0);
        @(posedge clk);
        #1;
        apbRead(STATUS, data);
        checkReg("STATUS", data, 0);
        checkState("state", histState_t'(data[6:4]), IDLE);
        apbTransfer(1'b0, 12'h00C, '0, 1'b1, data);
        apbTransfer(1'b0, 12'h200, '0, 1'b1, data);    // first bin past the end
        for (int r = 0; r < 4; r++) begin
            runRow(stimTable[r], r == 0);
        end
        apbRead(APB_ADDR_BITS'(BINBASE + 4 * 33), data);
        checkCount("bin 33", data[countBits-1:0], 4'hf);
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
design/histPkg.sv
design/histRam.sv
design/histController.sv
design/histApbRegs.sv
design/histTop.sv
tests/histTb.sv

// File: Makefile
# Verilator build for the photon histogram unit

VERILATOR  ?= verilator
FILELIST   ?= sources.f
LINT_TOP   ?= histTop
SIM_TOP    ?= histTb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= ALL CHECKS PASSED
FAIL_TEXT  ?= CHECKS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(SIM_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(SIM_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
